/* hw/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath widths
`define CORE_BYTE_W 8
`define CORE_ADDR_W 16

`define CORE_REG_COUNT 8
`define CORE_REG_H 3'd4
`define CORE_REG_L 3'd5
`define CORE_REG_MEM 3'd6 // (HL) slot, also the immediate marker
`define CORE_REG_A 3'd7

`define CORE_RESET_PC 16'h0000

// Opcode groups in bits 7:6
`define CORE_GRP_IMM 2'b00
`define CORE_GRP_LD 2'b01
`define CORE_GRP_ALU 2'b10
`define CORE_GRP_MISC 2'b11

`define CORE_OP_JP_NN 8'hC3
`define CORE_OP_JP_CC_LO 3'b010 // Low field of JP cc,nn

`endif

/* hw/core_pkg.sv */
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_BYTE_W-1:0] byte_t;
    typedef logic [`CORE_ADDR_W-1:0] addr_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // Same order as the ooo field of the opcode
    typedef enum logic [2:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_and,
        alu_xor,
        alu_or,
        alu_cp
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_rdata,
        wb_reg
    } wb_src_t;

    typedef enum logic {
        b_reg,
        b_rdata
    } alu_b_src_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_imm,
        st_addr_lo,
        st_addr_hi
    } seq_state_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

`include "core_defs.svh"

module reg_file (
    input  logic               clock,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rd_a_idx,
    input  core_pkg::reg_idx_t rd_b_idx,
    input  logic               wr_en,
    input  core_pkg::reg_idx_t wr_idx,
    input  core_pkg::byte_t    wdata,
    output core_pkg::byte_t    rd_a,
    output core_pkg::byte_t    rd_b,
    output core_pkg::byte_t    acc,
    output core_pkg::addr_t    hl
);
    import core_pkg::*;

    byte_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CORE_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wdata;
        end
    end

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];
    assign acc  = regs[`CORE_REG_A]; // Fixed ALU operand A
    assign hl   = {regs[`CORE_REG_H], regs[`CORE_REG_L]};

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`default_nettype none

`include "core_defs.svh"

module execute_unit (
    input  logic                 clock,
    input  logic                 rst_n,
    input  core_pkg::alu_op_t    alu_op,
    input  logic                 alu_en,
    input  core_pkg::alu_b_src_t b_src,
    input  core_pkg::wb_src_t    wb_src,
    input  core_pkg::byte_t      acc,
    input  core_pkg::byte_t      rd_b,
    input  core_pkg::byte_t      mem_rdata,
    input  logic [1:0]           cond_sel,
    output core_pkg::byte_t      rf_wdata,
    output logic                 cond_true
);
    import core_pkg::*;

    byte_t b_opnd;
    byte_t alu_res;
    logic [`CORE_BYTE_W:0] ext_a;
    logic [`CORE_BYTE_W:0] ext_b;
    logic [`CORE_BYTE_W:0] carry_in;
    logic [`CORE_BYTE_W:0] ext_res; // Top bit is carry or borrow
    logic z_flag;
    logic c_flag;

    assign b_opnd   = (b_src == b_rdata) ? mem_rdata : rd_b;
    assign ext_a    = {1'b0, acc};
    assign ext_b    = {1'b0, b_opnd};
    assign carry_in = {{`CORE_BYTE_W{1'b0}}, c_flag};

    always_comb
    begin
        case (alu_op)
            alu_add:         ext_res = ext_a + ext_b;
            alu_adc:         ext_res = ext_a + ext_b + carry_in;
            alu_sub, alu_cp: ext_res = ext_a - ext_b;
            alu_sbc:         ext_res = ext_a - ext_b - carry_in;
            // Logic ops leave the top bit clear, so C drops to 0
            alu_and:         ext_res = {1'b0, acc & b_opnd};
            alu_xor:         ext_res = {1'b0, acc ^ b_opnd};
            alu_or:          ext_res = {1'b0, acc | b_opnd};
            default:         ext_res = '0;
        endcase
    end

    assign alu_res = ext_res[`CORE_BYTE_W-1:0];

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            z_flag <= 1'b0;
            c_flag <= 1'b0;
        end
        else if (alu_en)
        begin
            z_flag <= (alu_res == '0);
            c_flag <= ext_res[`CORE_BYTE_W];
        end
    end

    always_comb
    begin
        case (wb_src)
            wb_rdata: rf_wdata = mem_rdata; // LD r,n
            wb_reg:   rf_wdata = rd_b;      // LD r,r'
            default:  rf_wdata = alu_res;
        endcase
    end

    // cc field: NZ, Z, NC, C
    always_comb
    begin
        case (cond_sel)
            2'b00:   cond_true = ~z_flag;
            2'b01:   cond_true = z_flag;
            2'b10:   cond_true = ~c_flag;
            default: cond_true = c_flag;
        endcase
    end

endmodule

`default_nettype wire

/* hw/sequencer.sv */
`default_nettype none

`include "core_defs.svh"

module sequencer (
    input  logic                 clock,
    input  logic                 rst_n,
    input  core_pkg::byte_t      mem_rdata,
    input  core_pkg::addr_t      hl,
    input  logic                 cond_true,
    output core_pkg::addr_t      mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output core_pkg::reg_idx_t   rd_a_idx,
    output core_pkg::reg_idx_t   rd_b_idx,
    output core_pkg::reg_idx_t   wr_idx,
    output logic                 wr_en,
    output logic                 alu_en,
    output core_pkg::alu_op_t    alu_op,
    output core_pkg::alu_b_src_t b_src,
    output core_pkg::wb_src_t    wb_src,
    output logic [1:0]           cond_sel
);
    import core_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    addr_t      pc;
    addr_t      addr_buf;
    addr_t      fetch_addr;
    byte_t      ir;
    byte_t      op;
    logic       jp_taken;
    logic [1:0] grp;
    reg_idx_t   dst;
    reg_idx_t   src;
    alu_op_t    op_alu;
    logic       is_ld_rr;
    logic       is_st_hl;
    logic       is_alu_r;
    logic       is_ld_rn;
    logic       is_alu_n;
    logic       is_jp;
    logic       is_cp;

    // Opcode arrives on the bus during decode, later states use the latched copy
    assign op     = (state == st_decode) ? mem_rdata : ir;
    assign grp    = op[7:6];
    assign dst    = op[5:3];
    assign src    = op[2:0];
    assign op_alu = alu_op_t'(op[5:3]);
    assign is_cp  = (op_alu == alu_cp);

    assign is_ld_rr = (grp == `CORE_GRP_LD) && (dst != `CORE_REG_MEM) && (src != `CORE_REG_MEM);
    assign is_st_hl = (grp == `CORE_GRP_LD) && (dst == `CORE_REG_MEM) && (src != `CORE_REG_MEM);
    assign is_alu_r = (grp == `CORE_GRP_ALU) && (src != `CORE_REG_MEM);
    assign is_ld_rn = (grp == `CORE_GRP_IMM) && (src == `CORE_REG_MEM) && (dst != `CORE_REG_MEM);
    assign is_alu_n = (grp == `CORE_GRP_MISC) && (src == `CORE_REG_MEM);
    assign is_jp    = (op == `CORE_OP_JP_NN) ||
                      ((grp == `CORE_GRP_MISC) && !op[5] && (src == `CORE_OP_JP_CC_LO));

    assign cond_sel = ir[4:3];

    // Buffer holds {lo, hi} after both bytes, swap back for the target
    assign fetch_addr = jp_taken ? {addr_buf[7:0], addr_buf[15:8]} : pc;

    always_comb
    begin
        mem_addr   = pc;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        rd_a_idx   = `CORE_REG_A;
        rd_b_idx   = src;
        wr_en      = 1'b0;
        wr_idx     = dst;
        alu_en     = 1'b0;
        alu_op     = op_alu;
        b_src      = b_reg;
        wb_src     = wb_alu;
        next_state = st_fetch;
        case (state)
            st_fetch:
            begin
                mem_addr   = fetch_addr;
                mem_read   = 1'b1;
                next_state = st_decode;
            end
            st_decode:
            begin
                if (is_ld_rr)
                begin
                    wr_en  = 1'b1;
                    wb_src = wb_reg;
                end
                else if (is_st_hl)
                begin
                    mem_addr  = hl;
                    mem_write = 1'b1;
                    rd_a_idx  = src; // Store data straight from the register
                end
                else if (is_alu_r)
                begin
                    alu_en = 1'b1;
                    wr_en  = !is_cp;
                    wr_idx = `CORE_REG_A;
                end
                else if (is_ld_rn || is_alu_n)
                begin
                    mem_read   = 1'b1;
                    next_state = st_imm;
                end
                else if (is_jp)
                begin
                    mem_read   = 1'b1;
                    next_state = st_addr_lo;
                end
            end
            st_imm:
            begin
                if (is_alu_n)
                begin
                    b_src  = b_rdata;
                    alu_en = 1'b1;
                    wr_en  = !is_cp;
                    wr_idx = `CORE_REG_A;
                end
                else
                begin
                    wr_en  = 1'b1;
                    wb_src = wb_rdata;
                end
            end
            st_addr_lo:
            begin
                mem_read   = 1'b1;
                next_state = st_addr_hi;
            end
            default:
            begin
                next_state = st_fetch;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= st_fetch;
            pc       <= `CORE_RESET_PC;
            jp_taken <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (mem_read)
            begin
                pc <= mem_addr + addr_t'(1); // Step past each byte read
            end
            if (state == st_fetch)
            begin
                jp_taken <= 1'b0;
            end
            else if (state == st_addr_hi)
            begin
                jp_taken <= (ir == `CORE_OP_JP_NN) || cond_true;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == st_decode)
        begin
            ir <= mem_rdata;
        end
        if (state == st_addr_lo || state == st_addr_hi)
        begin
            addr_buf <= {addr_buf[7:0], mem_rdata};
        end
    end

endmodule

`default_nettype wire

/* hw/core_top.sv */
`default_nettype none

module core_top (
    input  logic            clock,
    input  logic            rst_n,
    input  core_pkg::byte_t mem_rdata,
    output core_pkg::addr_t mem_addr,
    output logic            mem_read,
    output logic            mem_write,
    output core_pkg::byte_t mem_wdata
);
    import core_pkg::*;

    reg_idx_t   rd_a_idx;
    reg_idx_t   rd_b_idx;
    reg_idx_t   wr_idx;
    logic       wr_en;
    logic       alu_en;
    logic       cond_true;
    logic [1:0] cond_sel;
    alu_op_t    alu_op;
    alu_b_src_t b_src;
    wb_src_t    wb_src;
    byte_t      rd_b;
    byte_t      acc;
    byte_t      rf_wdata;
    addr_t      hl;

    sequencer u_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .hl        (hl),
        .cond_true (cond_true),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .wr_idx    (wr_idx),
        .wr_en     (wr_en),
        .alu_en    (alu_en),
        .alu_op    (alu_op),
        .b_src     (b_src),
        .wb_src    (wb_src),
        .cond_sel  (cond_sel)
    );

    // Port A doubles as the store data path
    reg_file u_reg_file (
        .clock    (clock),
        .rst_n    (rst_n),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wdata    (rf_wdata),
        .rd_a     (mem_wdata),
        .rd_b     (rd_b),
        .acc      (acc),
        .hl       (hl)
    );

    execute_unit u_execute_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .alu_op    (alu_op),
        .alu_en    (alu_en),
        .b_src     (b_src),
        .wb_src    (wb_src),
        .acc       (acc),
        .rd_b      (rd_b),
        .mem_rdata (mem_rdata),
        .cond_sel  (cond_sel),
        .rf_wdata  (rf_wdata),
        .cond_true (cond_true)
    );

endmodule

`default_nettype wire

/* verification/tb_core_top.sv */
`default_nettype none

`include "core_defs.svh"

module tb_core_top;
    import core_pkg::*;

    localparam int       CYCLE_LIMIT    = 4000;
    localparam reg_idx_t MARK_TAKEN     = 3'd2; // D holds 0x01
    localparam reg_idx_t MARK_NOT_TAKEN = 3'd3; // E holds 0x02

    logic  clock;
    logic  rst_n;
    byte_t mem_rdata;
    addr_t mem_addr;
    logic  mem_read;
    logic  mem_write;
    byte_t mem_wdata;

    byte_t mem [0:65535];
    logic  read_seen;
    addr_t read_addr;
    addr_t wr_addr_q [$];
    byte_t wr_data_q [$];
    int    cycle_count;
    logic  timed_out;
    int    error_count;
    int    check_count;
    int    seed;

    // Program image, expected stores and a register/flag model
    byte_t prog [$];
    addr_t exp_addr [$];
    byte_t exp_data [$];
    byte_t model_regs [8];
    logic  model_z;
    logic  model_c;

    core_top UUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial
    begin
        cycle_count = 0;
        timed_out   = 1'b0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycle_count++;
        end
        timed_out = 1'b1;
        $display("Timeout: the run was stopped after %0d cycles", cycle_count);
        finish_run();
    end

    // Strobes are sampled mid-cycle
    initial
    begin
        read_seen = 1'b0;
        read_addr = '0;
        forever
        begin
            @(negedge clock);
            read_seen = mem_read;
            read_addr = mem_addr;
            if (rst_n && mem_write)
            begin
                wr_addr_q.push_back(mem_addr);
                wr_data_q.push_back(mem_wdata);
            end
        end
    end

    initial
    begin
        mem_rdata = '0;
        forever
        begin
            @(posedge clock);
            #1;
            if (read_seen)
            begin
                mem_rdata = mem[read_addr]; // Data one cycle after the strobe
            end
        end
    end

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at time %0t: %s store data 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at time %0t: %s store address 0x%04h, expected 0x%04h",
                     $time, what, got, exp);
        end
    endtask

    // Returns {Z, C, result}
    function automatic logic [9:0] alu_model(alu_op_t op, byte_t a, byte_t b, logic cin);
        logic [8:0] sum;
        byte_t      res;
        logic       carry;
        sum   = '0;
        res   = '0;
        carry = 1'b0;
        case (op)
            alu_add, alu_adc:
            begin
                sum   = {1'b0, a} + {1'b0, b} + ((op == alu_adc) ? {8'd0, cin} : 9'd0);
                res   = sum[7:0];
                carry = sum[8];
            end
            alu_sub, alu_cp:
            begin
                res   = a - b;
                carry = (a < b); // Borrow
            end
            alu_sbc:
            begin
                res   = a - b - {7'd0, cin};
                carry = ({1'b0, a} < ({1'b0, b} + {8'd0, cin}));
            end
            alu_and: res = a & b;
            alu_xor: res = a ^ b;
            alu_or:  res = a | b;
            default: res = '0;
        endcase
        return {res == '0, carry, res};
    endfunction

    task automatic start_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        model_regs = '{default: '0};
        model_z    = 1'b0;
        model_c    = 1'b0;
    endtask

    task automatic apply_alu(input alu_op_t op, input byte_t b);
        logic [9:0] out;
        out     = alu_model(op, model_regs[`CORE_REG_A], b, model_c);
        model_z = out[9];
        model_c = out[8];
        if (op != alu_cp)
        begin
            model_regs[`CORE_REG_A] = out[7:0];
        end
    endtask

    task automatic emit_ld_rn(input reg_idx_t r, input byte_t n);
        prog.push_back({2'b00, r, 3'b110});
        prog.push_back(n);
        model_regs[r] = n;
    endtask

    task automatic emit_ld_rr(input reg_idx_t d, input reg_idx_t s);
        prog.push_back({2'b01, d, s});
        model_regs[d] = model_regs[s];
    endtask

    task automatic emit_store(input reg_idx_t r);
        prog.push_back({2'b01, 3'b110, r});
        exp_addr.push_back({model_regs[`CORE_REG_H], model_regs[`CORE_REG_L]});
        exp_data.push_back(model_regs[r]);
    endtask

    task automatic emit_alu_r(input alu_op_t op, input reg_idx_t r);
        prog.push_back({2'b10, op, r});
        apply_alu(op, model_regs[r]);
    endtask

    task automatic emit_alu_n(input alu_op_t op, input byte_t n);
        prog.push_back({2'b11, op, 3'b110});
        prog.push_back(n);
        apply_alu(op, n);
    endtask

    task automatic emit_jp(input addr_t target);
        prog.push_back(`CORE_OP_JP_NN);
        prog.push_back(target[7:0]);
        prog.push_back(target[15:8]);
    endtask

    task automatic emit_halt();
        emit_jp(addr_t'(prog.size())); // Jump to itself
    endtask

    task automatic load_markers();
        emit_ld_rn(MARK_TAKEN, 8'h01);
        emit_ld_rn(MARK_NOT_TAKEN, 8'h02);
    endtask

    // JP cc,T ; LD (HL),E ; JP J ; T: LD (HL),D ; J:
    task automatic emit_branch(input logic [1:0] cc);
        int   start;
        logic taken;
        start = prog.size();
        case (cc)
            2'b00:   taken = !model_z;
            2'b01:   taken = model_z;
            2'b10:   taken = !model_c;
            default: taken = model_c;
        endcase
        prog.push_back({2'b11, 1'b0, cc, 3'b010});
        prog.push_back(byte_t'(start + 7));
        prog.push_back(byte_t'((start + 7) >> 8));
        prog.push_back({2'b01, 3'b110, MARK_NOT_TAKEN});
        emit_jp(addr_t'(start + 8));
        prog.push_back({2'b01, 3'b110, MARK_TAKEN});
        exp_addr.push_back({model_regs[`CORE_REG_H], model_regs[`CORE_REG_L]});
        exp_data.push_back(taken ? model_regs[MARK_TAKEN] : model_regs[MARK_NOT_TAKEN]);
    endtask

    task automatic run_program(input string name);
        int base;
        int seen;
        int waited;
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 65536; i++)
        begin
            mem[addr_t'(i)] = byte_t'(i ^ (i >> 8));
        end
        foreach (prog[i])
        begin
            mem[addr_t'(i)] = prog[i];
        end
        repeat (3) @(posedge clock);
        #1;
        base   = wr_data_q.size();
        rst_n  = 1'b1;
        waited = 0;
        while (wr_data_q.size() - base < exp_data.size() && waited < 20 * exp_data.size() + 40)
        begin
            @(posedge clock);
            waited++;
        end
        repeat (8) @(posedge clock); // Room for a stray store
        seen = wr_data_q.size() - base;
        if (seen != exp_data.size())
        begin
            error_count++;
            $display("%s: expected %0d stores but the core made %0d", name, exp_data.size(), seen);
        end
        for (int i = 0; i < seen && i < exp_data.size(); i++)
        begin
            compare_addr(wr_addr_q[base + i], exp_addr[i], name);
            compare_byte(wr_data_q[base + i], exp_data[i], name);
        end
    endtask

    task automatic test_load_store();
        start_program();
        emit_ld_rn(`CORE_REG_H, 8'h80);
        emit_ld_rn(`CORE_REG_L, 8'h10);
        for (int i = 0; i < 4; i++)
        begin
            emit_ld_rn(reg_idx_t'(i), byte_t'($random(seed)));
        end
        emit_ld_rn(`CORE_REG_A, byte_t'($random(seed)));
        for (int i = 0; i < 8; i++)
        begin
            if (i != 6)
            begin
                emit_store(reg_idx_t'(i));
            end
        end
        emit_halt();
        run_program("LD r,n and LD (HL),r");
    endtask

    task automatic test_reg_copy();
        start_program();
        emit_ld_rn(`CORE_REG_H, 8'h80);
        emit_ld_rn(`CORE_REG_L, 8'h20);
        emit_ld_rn(`CORE_REG_A, 8'h3C);
        emit_alu_n(alu_sub, 8'h3C); // Z set, C clear
        emit_ld_rn(3'd1, 8'h5A);
        emit_ld_rr(3'd0, 3'd1);
        emit_ld_rr(3'd2, 3'd0);
        emit_ld_rr(3'd3, 3'd2);
        emit_ld_rr(`CORE_REG_A, 3'd3);
        emit_store(3'd0);
        emit_store(3'd2);
        emit_store(3'd3);
        emit_store(`CORE_REG_A);
        load_markers();
        emit_branch(2'b01);
        emit_branch(2'b10);
        emit_halt();
        run_program("LD r,r'");
    endtask

    task automatic test_alu_flags();
        byte_t   a;
        byte_t   b;
        alu_op_t op;
        start_program();
        emit_ld_rn(`CORE_REG_H, 8'h81);
        emit_ld_rn(`CORE_REG_L, 8'h00);
        load_markers();
        for (int i = 0; i < 20; i++)
        begin
            a  = byte_t'($random(seed));
            b  = (i % 5 == 0) ? a : byte_t'($random(seed)); // Equal pairs reach Z
            op = alu_op_t'(3'(i % 8));
            emit_ld_rn(`CORE_REG_A, a);
            if ((i / 8) % 2 == 1)
            begin
                emit_alu_n(op, b);
            end
            else
            begin
                emit_ld_rn(3'd0, b);
                emit_alu_r(op, 3'd0);
            end
            emit_store(`CORE_REG_A);
            for (int cc = 0; cc < 4; cc++)
            begin
                emit_branch(2'(cc));
            end
        end
        emit_halt();
        run_program("ALU and flags");
    endtask

    task automatic test_jump_reset();
        int skip;
        start_program();
        emit_ld_rn(`CORE_REG_H, 8'h82);
        emit_ld_rn(`CORE_REG_L, 8'h00);
        emit_ld_rn(`CORE_REG_A, 8'hA5);
        emit_store(`CORE_REG_A);
        skip = prog.size() + 4;
        emit_jp(addr_t'(skip));
        prog.push_back({2'b01, 3'b110, `CORE_REG_A}); // Jumped over
        emit_ld_rn(`CORE_REG_A, 8'h5C);
        emit_store(`CORE_REG_A);
        emit_halt();
        run_program("JP nn");
        run_program("JP nn after a second reset");
    endtask

    task automatic test_nop();
        start_program();
        emit_ld_rn(`CORE_REG_H, 8'h83);
        emit_ld_rn(`CORE_REG_L, 8'h00);
        emit_ld_rn(3'd0, 8'h33);
        emit_ld_rn(3'd1, 8'h44);
        emit_ld_rn(`CORE_REG_A, 8'h55);
        prog.push_back(8'h76);
        prog.push_back(8'h46); // LD B,(HL)
        prog.push_back(8'h4E);
        prog.push_back(8'h7E);
        emit_store(3'd0);
        emit_store(3'd1);
        emit_store(`CORE_REG_A);
        emit_halt();
        run_program("NOP opcodes");
    endtask

    initial
    begin
        rst_n       = 1'b0;
        error_count = 0;
        check_count = 0;
        seed        = 14955;
        test_load_store();
        test_reg_copy();
        test_alu_flags();
        test_jump_reset();
        test_nop();
        finish_run();
    end

endmodule

`default_nettype wire

/* core_top.f */
+incdir+hw
hw/core_pkg.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/sequencer.sv
hw/core_top.sv
verification/tb_core_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_core_top
FILELIST  = core_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
